// ==== include/video_settings.svh ====
`ifndef VIDEO_SETTINGS_SVH
`define VIDEO_SETTINGS_SVH

// 640x480 horizontal timing in pixels
`define H_SYNC      96
`define H_BACK      48
`define H_DISP      640
`define H_FRONT     16

// vertical timing in lines
`define V_SYNC      2
`define V_BACK      33
`define V_DISP      480
`define V_FRONT     10

// active sync level, 0 is negative
`define HSYNC_POL   1'b0
`define VSYNC_POL   1'b0

// bits per TMDS symbol, also clks per pixel
`define SYMBOL_BITS 10

`endif

// ==== logic/dvi_pattern_top.sv ====
`include "video_settings.svh"

module dvi_pattern_top #(
    parameter int h_sync  = `H_SYNC,
    parameter int h_back  = `H_BACK,
    parameter int h_disp  = `H_DISP,
    parameter int h_front = `H_FRONT,
    parameter int v_sync  = `V_SYNC,
    parameter int v_back  = `V_BACK,
    parameter int v_disp  = `V_DISP,
    parameter int v_front = `V_FRONT
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       push_sw,
    output logic [2:0] tmds_data,
    output logic       tmds_clk
);
    import video_pkg::*;
    import tmds_pkg::*;

    logic    pixel_tick;
    sync_t   timing_sync;
    pos_t    x;
    pos_t    y;
    pixel_t  pixel;
    enc_in_t enc_in [3];
    symbol_t symbols [3];

    video_timing #(
        .h_sync  (h_sync),
        .h_back  (h_back),
        .h_disp  (h_disp),
        .h_front (h_front),
        .v_sync  (v_sync),
        .v_back  (v_back),
        .v_disp  (v_disp),
        .v_front (v_front)
    ) u_video_timing (
        .clk        (clk),
        .reset      (reset),
        .pixel_tick (pixel_tick),
        .sync       (timing_sync),
        .x          (x),
        .y          (y)
    );

    pattern_draw #(
        .h_disp (h_disp)
    ) u_pattern_draw (
        .clk        (clk),
        .reset      (reset),
        .pixel_tick (pixel_tick),
        .push_sw    (push_sw),
        .sync       (timing_sync),
        .x          (x),
        .y          (y),
        .pixel      (pixel)
    );

    // syncs ride on the blue channel as c0/c1
    assign enc_in[0] = '{de: pixel.sync.de, ctl: {pixel.sync.vsync, pixel.sync.hsync},
                         data: pixel.rgb.blue};
    assign enc_in[1] = '{de: pixel.sync.de, ctl: 2'b00, data: pixel.rgb.green};
    assign enc_in[2] = '{de: pixel.sync.de, ctl: 2'b00, data: pixel.rgb.red};

    for (genvar ch = 0; ch < 3; ch++) begin : g_enc
        tmds_encoder u_tmds_encoder (
            .clk        (clk),
            .reset      (reset),
            .pixel_tick (pixel_tick),
            .enc        (enc_in[ch]),
            .symbol     (symbols[ch])
        );
    end

    tmds_serializer u_tmds_serializer (
        .clk        (clk),
        .reset      (reset),
        .pixel_tick (pixel_tick),
        .symbols    (symbols),
        .tmds_data  (tmds_data),
        .tmds_clk   (tmds_clk)
    );

endmodule

// ==== logic/pattern_draw.sv ====
`include "video_settings.svh"

module pattern_draw #(
    parameter int h_disp = `H_DISP
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              pixel_tick,
    input  logic              push_sw,
    input  video_pkg::sync_t  sync,
    input  video_pkg::pos_t   x,
    input  video_pkg::pos_t   y,
    output video_pkg::pixel_t pixel
);
    import video_pkg::*;

    localparam int BAR_W = h_disp / 8;

    pos_t       bar_cnt;
    logic [2:0] bar_idx;
    rgb_t       color;

    // bar index follows x along the active line
    always_ff @(posedge clk) begin
        if (reset) begin
            bar_cnt <= '0;
            bar_idx <= '0;
        end else if (pixel_tick) begin
            if (!sync.de) begin
                bar_cnt <= '0;
                bar_idx <= '0;
            end else if (bar_cnt == pos_t'(BAR_W - 1)) begin
                bar_cnt <= '0;
                bar_idx <= bar_idx + 1'b1;
            end else begin
                bar_cnt <= bar_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        if (!sync.de) begin
            color = '0;
        end else if (push_sw) begin
            color.red   = {8{bar_idx[2]}};
            color.green = {8{bar_idx[1]}};
            color.blue  = {8{bar_idx[0]}};
        end else begin
            color.red   = x[7:0] + y[7:0];
            color.green = y[7:0];
            color.blue  = x[7:0];
        end
    end

    // sync delayed one tick along with the colour
    always_ff @(posedge clk) begin
        if (reset) begin
            pixel <= '{sync: '{hsync: ~`HSYNC_POL, vsync: ~`VSYNC_POL, de: 1'b0}, rgb: '0};
        end else if (pixel_tick) begin
            pixel <= '{sync: sync, rgb: color};
        end
    end

endmodule

// ==== logic/tmds_encoder.sv ====
module tmds_encoder (
    input  logic              clk,
    input  logic              reset,
    input  logic              pixel_tick,
    input  tmds_pkg::enc_in_t enc,
    output tmds_pkg::symbol_t symbol
);
    import tmds_pkg::*;

    logic [3:0]        n1_data;
    logic              use_xnor;
    logic [8:0]        q_m;
    logic [3:0]        n1_qm;
    logic signed [5:0] q_bal;
    logic signed [5:0] disparity;
    logic signed [5:0] disparity_next;
    symbol_t           data_sym;
    symbol_t           ctl_sym;

    // transition minimisation
    always_comb begin
        n1_data  = 4'($countones(enc.data));
        use_xnor = (n1_data > 4'd4) || (n1_data == 4'd4 && !enc.data[0]);
        q_m[0]   = enc.data[0];
        for (int i = 1; i < 8; i++) begin
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ enc.data[i]) : (q_m[i-1] ^ enc.data[i]);
        end
        q_m[8] = ~use_xnor;
    end

    // ones minus zeros of the minimised byte
    assign n1_qm = 4'($countones(q_m[7:0]));
    assign q_bal = $signed({1'b0, n1_qm, 1'b0}) - 6'sd8;

    // dc balance against running disparity
    always_comb begin
        if (disparity == 6'sd0 || q_bal == 6'sd0) begin
            data_sym = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            if (q_m[8]) begin
                disparity_next = disparity + q_bal;
            end else begin
                disparity_next = disparity - q_bal;
            end
        end else if ((disparity > 6'sd0 && q_bal > 6'sd0)
                  || (disparity < 6'sd0 && q_bal < 6'sd0)) begin
            data_sym       = {1'b1, q_m[8], ~q_m[7:0]};
            disparity_next = disparity + (q_m[8] ? 6'sd2 : 6'sd0) - q_bal;
        end else begin
            data_sym       = {1'b0, q_m[8], q_m[7:0]};
            disparity_next = disparity - (q_m[8] ? 6'sd0 : 6'sd2) + q_bal;
        end
    end

    always_comb begin
        case (enc.ctl)
            2'b00:   ctl_sym = CTL_00;
            2'b01:   ctl_sym = CTL_01;
            2'b10:   ctl_sym = CTL_10;
            default: ctl_sym = CTL_11;
        endcase
    end

    // disparity restarts in every blanking period
    always_ff @(posedge clk) begin
        if (reset) begin
            symbol    <= '0;
            disparity <= '0;
        end else if (pixel_tick) begin
            if (enc.de) begin
                symbol    <= data_sym;
                disparity <= disparity_next;
            end else begin
                symbol    <= ctl_sym;
                disparity <= '0;
            end
        end
    end

endmodule

// ==== logic/tmds_pkg.sv ====
package tmds_pkg;

    typedef logic [9:0] symbol_t;

    // one encoder channel, ctl is {c1, c0}
    typedef struct packed {
        logic       de;
        logic [1:0] ctl;
        logic [7:0] data;
    } enc_in_t;

    // control period codes, bit 0 goes out first
    localparam symbol_t CTL_00 = 10'b1101010100;
    localparam symbol_t CTL_01 = 10'b0010101011;
    localparam symbol_t CTL_10 = 10'b0101010100;
    localparam symbol_t CTL_11 = 10'b1010101011;

endpackage

// ==== logic/tmds_serializer.sv ====
`include "video_settings.svh"

module tmds_serializer (
    input  logic              clk,
    input  logic              reset,
    input  logic              pixel_tick,
    input  tmds_pkg::symbol_t symbols [3],
    output logic [2:0]        tmds_data,
    output logic              tmds_clk
);
    import tmds_pkg::*;

    localparam int HALF = `SYMBOL_BITS / 2;

    // 1111100000 on the wire, lsb first
    localparam logic [`SYMBOL_BITS-1:0] CLK_PATTERN = {{HALF{1'b0}}, {HALF{1'b1}}};

    symbol_t                 shift_reg [3];
    logic [`SYMBOL_BITS-1:0] clk_shift;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 3; i++) begin
                shift_reg[i] <= '0;
            end
            clk_shift <= '0;
        end else if (pixel_tick) begin
            for (int i = 0; i < 3; i++) begin
                shift_reg[i] <= symbols[i];
            end
            clk_shift <= CLK_PATTERN;
        end else begin
            for (int i = 0; i < 3; i++) begin
                shift_reg[i] <= shift_reg[i] >> 1;
            end
            clk_shift <= clk_shift >> 1;
        end
    end

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            tmds_data[i] = shift_reg[i][0];
        end
    end

    assign tmds_clk = clk_shift[0];

endmodule

// ==== logic/video_pkg.sv ====
package video_pkg;

    // pixel position, wide enough for 2048 columns or lines
    typedef logic [10:0] pos_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } sync_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // sync travels with its colour
    typedef struct packed {
        sync_t sync;
        rgb_t  rgb;
    } pixel_t;

endpackage

// ==== logic/video_timing.sv ====
`include "video_settings.svh"

module video_timing #(
    parameter int h_sync  = `H_SYNC,
    parameter int h_back  = `H_BACK,
    parameter int h_disp  = `H_DISP,
    parameter int h_front = `H_FRONT,
    parameter int v_sync  = `V_SYNC,
    parameter int v_back  = `V_BACK,
    parameter int v_disp  = `V_DISP,
    parameter int v_front = `V_FRONT
) (
    input  logic             clk,
    input  logic             reset,
    output logic             pixel_tick,
    output video_pkg::sync_t sync,
    output video_pkg::pos_t  x,
    output video_pkg::pos_t  y
);
    import video_pkg::*;

    localparam int H_TOTAL    = h_sync + h_back + h_disp + h_front;
    localparam int V_TOTAL    = v_sync + v_back + v_disp + v_front;
    localparam int H_DE_START = h_sync + h_back;
    localparam int V_DE_START = v_sync + v_back;
    localparam int DIV_W      = $clog2(`SYMBOL_BITS);

    logic [DIV_W-1:0] div_cnt;
    pos_t             h_cnt;
    pos_t             v_cnt;
    sync_t            sync_next;

    // one tick per symbol
    always_ff @(posedge clk) begin
        if (reset || pixel_tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign pixel_tick = (div_cnt == DIV_W'(`SYMBOL_BITS - 1));

    // counters start at the top-left of sync
    always_ff @(posedge clk) begin
        if (reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (pixel_tick) begin
            if (h_cnt == pos_t'(H_TOTAL - 1)) begin
                h_cnt <= '0;
                if (v_cnt == pos_t'(V_TOTAL - 1)) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        sync_next.hsync = (h_cnt < pos_t'(h_sync)) ? `HSYNC_POL : ~`HSYNC_POL;
        sync_next.vsync = (v_cnt < pos_t'(v_sync)) ? `VSYNC_POL : ~`VSYNC_POL;
        sync_next.de    = (h_cnt >= pos_t'(H_DE_START))
                       && (h_cnt < pos_t'(H_DE_START + h_disp))
                       && (v_cnt >= pos_t'(V_DE_START))
                       && (v_cnt < pos_t'(V_DE_START + v_disp));
    end

    // x cleared in hsync, y cleared in vsync, both step on de
    always_ff @(posedge clk) begin
        if (reset) begin
            sync <= '{hsync: ~`HSYNC_POL, vsync: ~`VSYNC_POL, de: 1'b0};
            x    <= '0;
            y    <= '0;
        end else if (pixel_tick) begin
            sync <= sync_next;
            if (sync.hsync == `HSYNC_POL) begin
                x <= '0;
            end else if (sync.de) begin
                x <= x + 1'b1;
            end
            if (sync.vsync == `VSYNC_POL) begin
                y <= '0;
            end else if (sync.de && !sync_next.de) begin
                y <= y + 1'b1;
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the DVI pattern testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f sim.f --top-module dvi_tb -o dvi_tb

./obj_dir/dvi_tb | tee sim.log

if grep -q "Verification failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
if ! grep -q "Verification passed" sim.log; then
    echo "simulation ended without a result line, see sim.log"
    exit 1
fi
echo "simulation finished cleanly"

// ==== sim.f ====
+incdir+include
logic/video_pkg.sv
logic/tmds_pkg.sv
logic/video_timing.sv
logic/pattern_draw.sv
logic/tmds_encoder.sv
logic/tmds_serializer.sv
logic/dvi_pattern_top.sv
verif/dvi_tb.sv

// ==== verif/dvi_tb.sv ====
module dvi_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import video_pkg::*;
    import tmds_pkg::*;

    localparam int H_SYNC_T    = 4;
    localparam int H_BACK_T    = 4;
    localparam int H_DISP_T    = 16;
    localparam int H_FRONT_T   = 4;
    localparam int V_SYNC_T    = 2;
    localparam int V_BACK_T    = 2;
    localparam int V_DISP_T    = 6;
    localparam int V_FRONT_T   = 2;
    localparam int H_TOTAL     = H_SYNC_T + H_BACK_T + H_DISP_T + H_FRONT_T;
    localparam int V_TOTAL     = V_SYNC_T + V_BACK_T + V_DISP_T + V_FRONT_T;
    localparam int H_DE_START  = H_SYNC_T + H_BACK_T;
    localparam int V_DE_START  = V_SYNC_T + V_BACK_T;
    localparam int BAR_W       = H_DISP_T / 8;
    // ten bit clocks per pixel
    localparam int FRAME_CLKS  = H_TOTAL * V_TOTAL * 10;
    localparam int WATCHDOG_NS = (6 * FRAME_CLKS + 2000) * 20;
    // clock lane word as collected with the first bit in bit 0
    localparam symbol_t CLOCK_WORD = 10'b0000011111;

    logic       clk;
    logic       reset;
    logic       push_sw;
    logic [2:0] tmds_data;
    logic       tmds_clk;

    int         mismatch_count = 0;
    int         fail_count     = 0;
    int         frames_done    = 0;
    int         symbols_seen   = 0;
    int         h_pos          = 0;
    int         v_pos          = 0;
    int         x_cnt          = 0;
    int         y_cnt          = 0;
    int         balance [3]    = '{0, 0, 0};
    logic [3:0] phase          = 4'd0;
    logic       monitor_on     = 1'b0;
    logic       lane_started   = 1'b0;
    logic       synced         = 1'b0;
    logic       bars_mode      = 1'b0;
    symbol_t    clk_bits;
    symbol_t    data_bits [3];

    dvi_pattern_top #(
        .h_sync  (H_SYNC_T),
        .h_back  (H_BACK_T),
        .h_disp  (H_DISP_T),
        .h_front (H_FRONT_T),
        .v_sync  (V_SYNC_T),
        .v_back  (V_BACK_T),
        .v_disp  (V_DISP_T),
        .v_front (V_FRONT_T)
    ) u_dut (
        .clk       (clk),
        .reset     (reset),
        .push_sw   (push_sw),
        .tmds_data (tmds_data),
        .tmds_clk  (tmds_clk)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [7:0] decode_data(symbol_t s);
        logic [7:0] d;
        logic [7:0] b;
        d    = s[9] ? ~s[7:0] : s[7:0];
        b[0] = d[0];
        for (int i = 1; i < 8; i++) begin
            b[i] = s[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
        end
        return b;
    endfunction

    // bit 2 flags a control code and the low bits hold {c1, c0}
    function automatic logic [2:0] decode_ctl(symbol_t s);
        case (s)
            10'b1101010100: return 3'b100;
            10'b0010101011: return 3'b101;
            10'b0101010100: return 3'b110;
            10'b1010101011: return 3'b111;
            default:        return 3'b000;
        endcase
    endfunction

    function automatic int ones_minus_zeros(symbol_t s);
        return 2 * $countones(s) - 10;
    endfunction

    function automatic rgb_t expected_rgb(int x, int y, logic bars);
        rgb_t c;
        int   k;
        k = x / BAR_W;
        if (bars) begin
            c.red   = {8{k[2]}};
            c.green = {8{k[1]}};
            c.blue  = {8{k[0]}};
        end else begin
            c.red   = 8'((x + y) % 256);
            c.green = 8'(y % 256);
            c.blue  = 8'(x % 256);
        end
        return c;
    endfunction

    task automatic check_rgb(rgb_t got, rgb_t exp, string what);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t: %s got %06h expected %06h", $time, what, got, exp);
        end
    endtask

    task automatic check_ctl(int ch, logic [1:0] got, logic [1:0] exp, string what);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t: %s on channel %0d got %b expected %b",
                     $time, what, ch, got, exp);
        end
    endtask

    task automatic check_symbol(symbol_t got, symbol_t exp, string what);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(int got, int exp, string what);
        if (got != exp) begin
            mismatch_count++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // position model locks on the first data symbol as the first active pixel
    task automatic take_symbol();
        logic [2:0] dec [3];
        logic       de;
        logic       in_active;
        logic [1:0] sync_ctl;
        rgb_t       got;
        for (int ch = 0; ch < 3; ch++) begin
            dec[ch] = decode_ctl(data_bits[ch]);
        end
        de = !dec[0][2];
        symbols_seen++;
        if (symbols_seen == 1) begin
            // encoders still hold their reset value
            for (int ch = 0; ch < 3; ch++) begin
                check_symbol(data_bits[ch], '0, "first symbol after reset");
            end
            return;
        end
        if (!synced) begin
            if (!de) begin
                return;
            end
            synced = 1'b1;
            h_pos  = H_DE_START;
            v_pos  = V_DE_START;
        end else if (h_pos == H_TOTAL - 1) begin
            h_pos = 0;
            v_pos = (v_pos == V_TOTAL - 1) ? 0 : v_pos + 1;
        end else begin
            h_pos++;
        end
        if (h_pos == 0 && v_pos == 0) begin
            check_count(y_cnt, V_DISP_T, "active lines in frame");
            y_cnt = 0;
            frames_done++;
        end
        in_active = (h_pos >= H_DE_START) && (h_pos < H_DE_START + H_DISP_T)
                 && (v_pos >= V_DE_START) && (v_pos < V_DE_START + V_DISP_T);
        if (de) begin
            if (!in_active) begin
                fail_count++;
                $display("data symbol outside the active area at h %0d v %0d", h_pos, v_pos);
            end
            for (int ch = 1; ch < 3; ch++) begin
                if (dec[ch][2]) begin
                    fail_count++;
                    $display("channel %0d sent a control code among data at %0t", ch, $time);
                end
            end
            got = '{red: decode_data(data_bits[2]), green: decode_data(data_bits[1]),
                    blue: decode_data(data_bits[0])};
            check_rgb(got, expected_rgb(x_cnt, y_cnt, bars_mode),
                      $sformatf("pixel (%0d,%0d)", x_cnt, y_cnt));
            for (int ch = 0; ch < 3; ch++) begin
                balance[ch] += ones_minus_zeros(data_bits[ch]);
                if (balance[ch] > 10 || balance[ch] < -10) begin
                    fail_count++;
                    $display("channel %0d line %0d is out of DC balance by %0d",
                             ch, y_cnt, balance[ch]);
                end
            end
            x_cnt++;
        end else begin
            if (x_cnt != 0) begin
                check_count(x_cnt, H_DISP_T, "data symbols in line");
                for (int ch = 0; ch < 3; ch++) begin
                    balance[ch] = 0;
                end
                x_cnt = 0;
                y_cnt++;
            end
            if (in_active) begin
                fail_count++;
                $display("control symbol inside the active area at h %0d v %0d", h_pos, v_pos);
            end
            // sync bits are low inside sync at negative polarity
            sync_ctl = {v_pos >= V_SYNC_T, h_pos >= H_SYNC_T};
            for (int ch = 0; ch < 3; ch++) begin
                if (!dec[ch][2]) begin
                    fail_count++;
                    $display("channel %0d sent no control code in blanking at %0t", ch, $time);
                end else begin
                    check_ctl(ch, dec[ch][1:0], (ch == 0) ? sync_ctl : 2'b00, "blanking control");
                end
            end
        end
    endtask

    // symbols framed from the first rise of the clock lane
    always @(negedge clk) begin
        if (monitor_on) begin
            if (!lane_started && tmds_clk !== 1'b1) begin
                if (tmds_data !== 3'b000) begin
                    fail_count++;
                    $display("data lanes not idle before the first load at %0t", $time);
                end
            end else begin
                lane_started    = 1'b1;
                clk_bits[phase] = tmds_clk;
                for (int ch = 0; ch < 3; ch++) begin
                    data_bits[ch][phase] = tmds_data[ch];
                end
                if (phase == 4'd9) begin
                    phase = 4'd0;
                    check_symbol(clk_bits, CLOCK_WORD, "clock lane word");
                    take_symbol();
                end else begin
                    phase = phase + 4'd1;
                end
            end
        end
    end

    task automatic wait_frame_done();
        int start;
        start = frames_done;
        while (frames_done == start) begin
            @(posedge clk);
        end
    endtask

    // delay from a frame boundary stays inside vertical blanking
    task automatic switch_in_blanking(logic level);
        repeat ($urandom % 600) @(posedge clk);
        push_sw   <= level;
        bars_mode <= level;
    endtask

    task automatic idle_after_reset();
        repeat (5) @(posedge clk);
        reset      <= 1'b0;
        monitor_on <= 1'b1;
        while (symbols_seen < 2) begin
            @(posedge clk);
        end
    endtask

    task automatic gradient_frame();
        wait_frame_done();
    endtask

    task automatic bar_frame();
        switch_in_blanking(1'b1);
        wait_frame_done();
    endtask

    task automatic back_to_gradient();
        switch_in_blanking(1'b0);
        wait_frame_done();
    endtask

    initial begin
        void'($urandom(93));
        reset   = 1'b1;
        push_sw = 1'b0;
        idle_after_reset();
        gradient_frame();
        bar_frame();
        back_to_gradient();
        $display("errors: %0d mismatches, %0d other failures, %0d frames checked",
                 mismatch_count, fail_count, frames_done);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("run timed out after %0d ns before the tests completed", WATCHDOG_NS);
        $display("Verification failed");
        $finish;
    end

endmodule
